//--- filelist.f
+incdir+hw
hw/us_pkg.sv
hw/us_cmd_regs.sv
hw/us_discovery_gen.sv
hw/us_frame_packer.sv
hw/us_packer_top.sv
testbench/us_packer_props.sv
testbench/tb_us_packer_top.sv

//--- hw/us_cmd_regs.sv
// Host command decoder, keeps the wideband frame interval and VNA mode for the packer
`timescale 1ns/10ps

module us_cmd_regs (
  input  logic            clk,
  input  logic            rst_n,
  input  us_pkg::us_cmd_t cmd,
  output us_pkg::us_cfg_t cfg
);

  logic [6:0] rx_count;

  assign rx_count = {2'b00, cmd.data.rx_cfg.nr_m1} + 7'd1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg.bs_interval <= 7'd1;
      cfg.vna         <= 1'b0;
    end else if (cmd.rqst) begin
      case (cmd.addr)
        6'h00: begin
          // More receivers or higher speed means fewer wideband frames
          cfg.bs_interval <= rx_count << cmd.data.rx_cfg.speed;
        end
        6'h09: begin
          cfg.vna <= cmd.data.vna_cfg.vna;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

//--- hw/us_discovery_gen.sv
// Discovery reply lookup, maps a byte index of the 60-byte reply to its content
`timescale 1ns/10ps
`include "us_macros.svh"

module us_discovery_gen (
  input  logic [5:0]        disc_index,
  input  logic              run,
  input  us_pkg::us_ident_t ident,
  output logic [7:0]        disc_byte
);

  localparam logic [7:0] BOARD_BYTE = {`US_BANDSCOPE_BITS, `US_BOARD};

  always_comb begin
    case (disc_index)
      6'd0:  disc_byte = 8'hef;
      6'd1:  disc_byte = 8'hfe;
      6'd2:  disc_byte = run ? 8'h03 : 8'h02;  // Busy vs idle
      6'd3:  disc_byte = ident.mac[47:40];
      6'd4:  disc_byte = ident.mac[39:32];
      6'd5:  disc_byte = ident.mac[31:24];
      6'd6:  disc_byte = ident.mac[23:16];
      6'd7:  disc_byte = ident.mac[15:8];
      6'd8:  disc_byte = ident.mac[7:0];
      6'd9:  disc_byte = `US_VERSION_MAJOR;
      6'd10: disc_byte = {ident.eeprom_config[7:5], 5'b00000};
      6'd11: disc_byte = 8'h00;
      6'd12: disc_byte = ident.static_ip[31:24];
      6'd13: disc_byte = ident.static_ip[23:16];
      6'd14: disc_byte = ident.static_ip[15:8];
      6'd15: disc_byte = ident.static_ip[7:0];
      6'd16: disc_byte = ident.alt_mac[15:8];
      6'd17: disc_byte = ident.alt_mac[7:0];
      6'd18: disc_byte = `US_NR;
      6'd19: disc_byte = BOARD_BYTE;
      6'd20: disc_byte = `US_VERSION_MINOR;
      default: begin
        // Filler also tells the host which board family answered
        disc_byte = ident.idhermeslite ? 8'h06 : 8'h01;
      end
    endcase
  end

endmodule

//--- hw/us_frame_packer.sv
// Upstream frame sequencer, streams discovery, EP6 and EP4 payloads to the UDP transmitter
`timescale 1ns/10ps
`include "us_macros.svh"

module us_frame_packer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  logic               have_ip,
  input  logic               wide_spectrum,
  input  logic               discovery,
  input  us_pkg::us_cfg_t    cfg,
  input  us_pkg::us_sample_t samples,
  output logic               us_tready,
  input  us_pkg::us_bs_t     bs,
  output logic               bs_tready,
  input  logic [39:0]        resp,
  output logic               resp_rqst,
  output logic               watchdog_up,
  output logic [5:0]         disc_index,
  input  logic [7:0]         disc_byte,
  input  logic               udp_tx_enable,
  output logic               udp_tx_request,
  output logic [7:0]         udp_tx_data,
  output logic [10:0]        udp_tx_length
);

  // State names the byte presented in that cycle
  localparam logic [3:0] S_IDLE      = 4'd0;
  localparam logic [3:0] S_REQ       = 4'd1;
  localparam logic [3:0] S_DISC      = 4'd2;
  localparam logic [3:0] S_HDR       = 4'd3;
  localparam logic [3:0] S_SYNC_RESP = 4'd4;
  localparam logic [3:0] S_RX2       = 4'd5;
  localparam logic [3:0] S_RX1       = 4'd6;
  localparam logic [3:0] S_RX0       = 4'd7;
  localparam logic [3:0] S_MIC1      = 4'd8;
  localparam logic [3:0] S_MIC0      = 4'd9;
  localparam logic [3:0] S_PAD       = 4'd10;
  localparam logic [3:0] S_WIDE_LO   = 4'd11;
  localparam logic [3:0] S_WIDE_HI   = 4'd12;

  localparam logic [1:0] K_DISC = 2'd0;
  localparam logic [1:0] K_EP6  = 2'd1;
  localparam logic [1:0] K_EP4  = 2'd2;

  logic [3:0]  state;
  logic [1:0]  kind;
  logic [10:0] byte_no;      // Bytes left after the current one
  logic [19:0] ep6_seq;
  logic [19:0] ep4_seq;
  logic [19:0] hdr_seq;
  logic [6:0]  bs_cnt;
  logic [6:0]  round_bytes;
  logic        mic_bit;

  logic        streaming;
  logic        ep6_go;
  logic        bs_due;
  logic        hdr_last;
  logic        sub_end;
  logic [3:0]  sub_next;

  assign streaming = (state != S_IDLE) && (state != S_REQ);
  assign ep6_go    = samples.tvalid && have_ip && run &&
                     (samples.tlength > `US_FILL_THRESHOLD);
  assign bs_due    = bs.tvalid && (bs_cnt == 7'd0);
  assign hdr_last  = (state == S_HDR) && (byte_no[2:0] == 3'd0);
  assign sub_end   = (byte_no[8:0] == 9'd0);
  assign sub_next  = byte_no[9] ? S_SYNC_RESP : S_IDLE;  // Second half or done
  assign hdr_seq   = (kind == K_EP4) ? ep4_seq : ep6_seq;

  assign disc_index = 6'(`US_DISC_LEN - 11'd1) - byte_no[5:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state         <= S_IDLE;
      kind          <= K_DISC;
      byte_no       <= '0;
      udp_tx_length <= '0;
      bs_cnt        <= 7'd1;
      round_bytes   <= '0;
      mic_bit       <= 1'b0;
      resp_rqst     <= 1'b0;
      watchdog_up   <= 1'b0;
    end else begin
      if (streaming) byte_no <= byte_no - 11'd1;

      case (state)
        S_IDLE: begin
          if (discovery) begin
            kind          <= K_DISC;
            udp_tx_length <= `US_DISC_LEN;
            state         <= S_REQ;
          end else if (ep6_go) begin
            kind          <= K_EP6;
            udp_tx_length <= `US_FRAME_LEN;
            state         <= S_REQ;
          end else if (bs_due) begin
            bs_cnt      <= cfg.bs_interval;
            watchdog_up <= ~watchdog_up;  // Heartbeat even with wideband off
            if (wide_spectrum) begin
              kind          <= K_EP4;
              udp_tx_length <= `US_FRAME_LEN;
              state         <= S_REQ;
            end
          end
        end

        S_REQ: begin
          if (udp_tx_enable) begin
            byte_no <= udp_tx_length - 11'd1;
            state   <= (kind == K_DISC) ? S_DISC : S_HDR;
          end
        end

        S_DISC: begin
          if (byte_no == 11'd0) state <= S_IDLE;
        end

        S_HDR: begin
          if (hdr_last) begin
            if (kind == K_EP4) begin
              state <= S_WIDE_LO;
            end else begin
              if (bs_cnt != 7'd0) bs_cnt <= bs_cnt - 7'd1;
              state <= S_SYNC_RESP;
            end
          end
        end

        S_SYNC_RESP: begin
          round_bytes <= '0;
          if (byte_no[8:0] == 9'd504) begin
            resp_rqst <= ~resp_rqst;  // Ask for the next response word
            state     <= S_RX2;
          end
        end

        S_RX2: begin
          round_bytes <= round_bytes + 7'd1;
          if (round_bytes == 7'd0) mic_bit <= samples.tuser[0];
          state <= sub_end ? sub_next : S_RX1;
        end

        S_RX1: begin
          round_bytes <= round_bytes + 7'd1;
          state       <= sub_end ? sub_next : S_RX0;
        end

        S_RX0: begin
          round_bytes <= round_bytes + 7'd1;
          if (sub_end) state <= sub_next;
          else state <= samples.tlast ? S_MIC1 : S_RX2;
        end

        S_MIC1: begin
          round_bytes <= round_bytes + 7'd1;
          state       <= sub_end ? sub_next : S_MIC0;
        end

        S_MIC0: begin
          round_bytes <= '0;
          if (sub_end) begin
            state <= sub_next;
          end else begin
            // Room left for one more full round
            state <= (byte_no[8:0] > {2'b00, round_bytes}) ? S_RX2 : S_PAD;
          end
        end

        S_PAD: begin
          if (sub_end) state <= sub_next;
        end

        S_WIDE_LO: begin
          state <= (byte_no == 11'd0) ? S_IDLE : S_WIDE_HI;
        end

        S_WIDE_HI: begin
          state <= (byte_no == 11'd0) ? S_IDLE : S_WIDE_LO;
        end

        default: state <= S_IDLE;
      endcase
    end
  end

  // Sequence numbers restart whenever the host stops the radio
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ep6_seq <= '0;
      ep4_seq <= '0;
    end else if (!run) begin
      ep6_seq <= '0;
      ep4_seq <= '0;
    end else if (hdr_last) begin
      if (kind == K_EP4) ep4_seq <= ep4_seq + 20'd1;
      else ep6_seq <= ep6_seq + 20'd1;
    end
  end

  assign udp_tx_request = (state == S_REQ);
  assign us_tready      = (state == S_RX0);      // Low byte goes out
  assign bs_tready      = (state == S_WIDE_HI);

  always_comb begin
    case (state)
      S_DISC: udp_tx_data = disc_byte;
      S_HDR: begin
        case (byte_no[2:0])
          3'd7: udp_tx_data = 8'hef;
          3'd6: udp_tx_data = 8'hfe;
          3'd5: udp_tx_data = 8'h01;
          3'd4: udp_tx_data = (kind == K_EP4) ? 8'h04 : 8'h06;  // Endpoint
          3'd3: udp_tx_data = 8'h00;
          3'd2: udp_tx_data = {4'h0, hdr_seq[19:16]};
          3'd1: udp_tx_data = hdr_seq[15:8];
          default: udp_tx_data = hdr_seq[7:0];
        endcase
      end
      S_SYNC_RESP: begin
        case (byte_no[2:0])
          3'd4: udp_tx_data = resp[39:32];
          3'd3: udp_tx_data = resp[31:24];
          3'd2: udp_tx_data = resp[23:16];
          3'd1: udp_tx_data = resp[15:8];
          3'd0: udp_tx_data = resp[7:0];
          default: udp_tx_data = 8'h7f;  // Sync
        endcase
      end
      S_RX2:     udp_tx_data = samples.tdata[23:16];
      S_RX1:     udp_tx_data = samples.tdata[15:8];
      S_RX0:     udp_tx_data = samples.tdata[7:0];
      S_MIC0:    udp_tx_data = {7'd0, cfg.vna & mic_bit};
      S_WIDE_LO: udp_tx_data = {bs.tdata[3:0], 4'h0};
      S_WIDE_HI: udp_tx_data = bs.tdata[11:4];
      default:   udp_tx_data = 8'h00;
    endcase
  end

endmodule

//--- hw/us_macros.svh
// Frame sizes, start thresholds and board identity constants, included by the upstream RTL
`ifndef US_MACROS_SVH
`define US_MACROS_SVH

// Payload lengths in bytes
`define US_DISC_LEN 11'd60
`define US_FRAME_LEN 11'd1032

// Sample FIFO words needed before an EP6 frame may start
`define US_FILL_THRESHOLD 11'd333

// Firmware version reported in discovery
`define US_VERSION_MAJOR 8'd73
`define US_VERSION_MINOR 8'd2

`define US_BOARD 6'd5
`define US_NR 8'd8

// Bandscope width code, see protocol wiki
`define US_BANDSCOPE_BITS 2'b01

`endif

//--- hw/us_packer_top.sv
// Upstream packer top level, joins command decoder, discovery lookup and frame sequencer
`timescale 1ns/10ps

module us_packer_top (
  input  logic               clk,
  input  logic               rst_n,
  input  us_pkg::us_cmd_t    cmd,
  input  us_pkg::us_sample_t samples,
  input  us_pkg::us_bs_t     bs,
  input  us_pkg::us_ident_t  ident,
  input  logic [39:0]        resp,
  input  logic               run,
  input  logic               have_ip,
  input  logic               wide_spectrum,
  input  logic               discovery,
  input  logic               udp_tx_enable,
  output logic               udp_tx_request,
  output logic [7:0]         udp_tx_data,
  output logic [10:0]        udp_tx_length,
  output logic               us_tready,
  output logic               bs_tready,
  output logic               resp_rqst,
  output logic               watchdog_up
);

  us_pkg::us_cfg_t cfg;
  logic [5:0]      disc_index;
  logic [7:0]      disc_byte;

  us_cmd_regs u_cmd_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .cmd   (cmd),
    .cfg   (cfg)
  );

  us_discovery_gen u_discovery_gen (
    .disc_index (disc_index),
    .run        (run),
    .ident      (ident),
    .disc_byte  (disc_byte)
  );

  us_frame_packer u_frame_packer (
    .clk            (clk),
    .rst_n          (rst_n),
    .run            (run),
    .have_ip        (have_ip),
    .wide_spectrum  (wide_spectrum),
    .discovery      (discovery),
    .cfg            (cfg),
    .samples        (samples),
    .us_tready      (us_tready),
    .bs             (bs),
    .bs_tready      (bs_tready),
    .resp           (resp),
    .resp_rqst      (resp_rqst),
    .watchdog_up    (watchdog_up),
    .disc_index     (disc_index),
    .disc_byte      (disc_byte),
    .udp_tx_enable  (udp_tx_enable),
    .udp_tx_request (udp_tx_request),
    .udp_tx_data    (udp_tx_data),
    .udp_tx_length  (udp_tx_length)
  );

endmodule

//--- hw/us_pkg.sv
// Shared types for the upstream packer: host command word, sample and bandscope streams, identity
package us_pkg;

  // Address 0 view of a host command word
  typedef struct packed {
    logic [5:0]  rsvd_hi;
    logic [1:0]  speed;      // 48/96/192/384 kHz
    logic [15:0] rsvd_mid;
    logic [4:0]  nr_m1;      // Receivers minus one
    logic [2:0]  rsvd_lo;
  } us_rx_cfg_t;

  // Address 9 view
  typedef struct packed {
    logic [7:0]  rsvd_hi;
    logic        vna;
    logic [22:0] rsvd_lo;
  } us_vna_cfg_t;

  typedef union packed {
    us_rx_cfg_t  rx_cfg;
    us_vna_cfg_t vna_cfg;
  } us_cmd_u;

  typedef struct packed {
    logic [5:0] addr;
    us_cmd_u    data;
    logic       rqst;
  } us_cmd_t;

  typedef struct packed {
    logic [23:0] tdata;
    logic        tlast;      // Last receiver of a round
    logic        tvalid;
    logic [1:0]  tuser;
    logic [10:0] tlength;    // FIFO fill level in words
  } us_sample_t;

  typedef struct packed {
    logic [11:0] tdata;
    logic        tvalid;
  } us_bs_t;

  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] static_ip;
    logic [15:0] alt_mac;
    logic [7:0]  eeprom_config;
    logic        idhermeslite;
  } us_ident_t;

  typedef struct packed {
    logic [6:0] bs_interval; // EP6 frames per EP4 frame
    logic       vna;
  } us_cfg_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the upstream packer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_us_packer_top -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
echo "Simulation finished without failure"
exit 0

//--- testbench/tb_us_packer_top.sv
// Directed testbench for the upstream packer, models sample FIFO, bandscope source and UDP sink
`timescale 1ns/10ps
`include "us_macros.svh"

module tb_us_packer_top;

  localparam int TMO  = 6000;
  localparam int MASK = 8191;

  logic clk = 1'b0;
  logic rst_n;
  us_pkg::us_cmd_t    cmd;
  us_pkg::us_sample_t samples;
  us_pkg::us_bs_t     bs;
  us_pkg::us_ident_t  ident;
  logic [39:0] resp;
  logic run, have_ip, wide_spectrum, discovery, udp_tx_enable;
  logic udp_tx_request, us_tready, bs_tready, resp_rqst, watchdog_up;
  logic [7:0]  udp_tx_data;
  logic [10:0] udp_tx_length;

  logic [23:0] swords [0:MASK];
  logic [1:0]  susers [0:MASK];
  logic [11:0] bwords [0:MASK];
  int sidx, bidx, exp_sidx, exp_bidx, nrx, fill, fill_period, toggles;
  logic svalid, bvalid, pop_s, pop_b, vna_exp;
  logic [19:0] exp_ep6_seq, exp_ep4_seq;
  logic [7:0]  cap [0:1031];

  always #4 clk = ~clk;

  us_packer_top u_dut (.*);

  always @(negedge clk) begin
    pop_s = us_tready;
    pop_b = bs_tready;
  end

  // Sample FIFO and bandscope models, head advances after each pop
  initial begin
    samples = '0;
    bs = '0;
    forever begin
      @(posedge clk);
      #2;
      if (pop_s) begin
        sidx = sidx + 1;
        fill = fill - 1;
      end
      if (pop_b) bidx = bidx + 1;
      if (fill_period != 0 && (int'($time / 8) % fill_period) == 0 && fill < 2000)
        fill = fill + 1;
      samples.tdata   = swords[sidx & MASK];
      samples.tuser   = susers[sidx & MASK];
      samples.tlast   = ((sidx % nrx) == nrx - 1);  // Rounds of nrx words
      samples.tvalid  = svalid;
      samples.tlength = 11'(fill);
      bs.tdata  = bwords[bidx & MASK];
      bs.tvalid = bvalid;
    end
  end

  task automatic fail_stop(string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(string name, int pos, logic [7:0] exp, logic [7:0] act);
    if (act !== exp)
      fail_stop($sformatf("[FAIL] %s byte %0d expected %02h actual %02h", name, pos, exp, act));
  endtask

  task automatic check_len(string name, logic [10:0] exp, logic [10:0] act);
    if (act !== exp)
      fail_stop($sformatf("[FAIL] %s length expected %0d actual %0d", name, exp, act));
  endtask

  task automatic check_resp(string name, logic [39:0] exp, logic [39:0] act);
    if (act !== exp)
      fail_stop($sformatf("[FAIL] %s resp expected %010h actual %010h", name, exp, act));
  endtask

  task automatic check_cfg(string name, us_pkg::us_cfg_t exp, us_pkg::us_cfg_t act);
    if (act !== exp)
      fail_stop($sformatf("[FAIL] %s cfg expected interval %0d vna %0b actual interval %0d vna %0b",
                          name, exp.bs_interval, exp.vna, act.bs_interval, act.vna));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic send_cmd(logic [5:0] addr, us_pkg::us_cmd_u data);
    cmd.addr = addr;
    cmd.data = data;
    cmd.rqst = 1'b1;
    next_cycle();
    cmd.rqst = 1'b0;
    next_cycle();
  endtask

  task automatic set_rx(int n, logic [1:0] spd);
    us_pkg::us_cmd_u d;
    us_pkg::us_cfg_t exp;
    d = '0;
    d.rx_cfg.nr_m1 = 5'(n - 1);
    d.rx_cfg.speed = spd;
    send_cmd(6'd0, d);
    exp.bs_interval = 7'(n << spd);
    exp.vna = vna_exp;
    check_cfg("rx command", exp, u_dut.cfg);
    nrx = n;
    sidx = 0;  // Fresh FIFO contents aligned to a round
    exp_sidx = 0;
  endtask

  // Waits for a request, enables after a random delay and captures the payload
  task automatic get_frame(string name, logic [10:0] len);
    int t;
    logic prev;
    t = 0;
    while (udp_tx_request !== 1'b1) begin
      next_cycle();
      t++;
      if (t > TMO) fail_stop($sformatf("%s: timeout waiting for a frame request", name));
    end
    discovery = 1'b0;
    check_len(name, len, udp_tx_length);
    repeat (1 + ($urandom % 5)) next_cycle();
    udp_tx_enable = 1'b1;
    next_cycle();
    udp_tx_enable = 1'b0;
    prev = resp_rqst;
    toggles = 0;
    for (int n = 0; n < int'(len); n++) begin
      @(negedge clk);
      cap[n] = udp_tx_data;
      if (resp_rqst !== prev) toggles++;
      prev = resp_rqst;
    end
    next_cycle();
  endtask

  task automatic expect_quiet(string name, int cycles);
    for (int i = 0; i < cycles; i++) begin
      next_cycle();
      if (udp_tx_request !== 1'b0) fail_stop($sformatf("%s: frame started when not allowed", name));
    end
  endtask

  function automatic logic [7:0] disc_expected(int i, logic r);
    if (i == 0) return 8'hef;
    if (i == 1) return 8'hfe;
    if (i == 2) return r ? 8'h03 : 8'h02;
    if (i >= 3 && i <= 8) return ident.mac[8*(8-i)+7 -: 8];
    if (i == 9) return `US_VERSION_MAJOR;
    if (i == 10) return {ident.eeprom_config[7:5], 5'b00000};
    if (i == 11) return 8'h00;
    if (i >= 12 && i <= 15) return ident.static_ip[8*(15-i)+7 -: 8];
    if (i >= 16 && i <= 17) return ident.alt_mac[8*(17-i)+7 -: 8];
    if (i == 18) return 8'd8;
    if (i == 19) return {2'b01, 6'd5};  // Bandscope bits over board id
    if (i == 20) return `US_VERSION_MINOR;
    return ident.idhermeslite ? 8'h06 : 8'h01;
  endfunction

  task automatic test_discovery(logic r);
    run = r;
    discovery = 1'b1;
    get_frame("discovery", 11'd60);
    for (int i = 0; i < 60; i++) check_byte("discovery", i, disc_expected(i, r), cap[i]);
  endtask

  task automatic check_header(string name, logic [7:0] ep, logic [19:0] seq);
    logic [7:0] hdr [0:7];
    hdr = '{8'hef, 8'hfe, 8'h01, ep, 8'h00, {4'h0, seq[19:16]}, seq[15:8], seq[7:0]};
    for (int i = 0; i < 8; i++) check_byte(name, i, hdr[i], cap[i]);
  endtask

  task automatic check_ep6(string name);
    int p, s, rem, len;
    logic [7:0] mic;
    logic [23:0] w;
    check_header(name, 8'h06, exp_ep6_seq);
    len = 3 * nrx + 2;
    for (int h = 0; h < 2; h++) begin
      s = 8 + 512 * h;
      for (int i = 0; i < 3; i++) check_byte(name, s + i, 8'h7f, cap[s+i]);
      check_resp(name, resp, {cap[s+3], cap[s+4], cap[s+5], cap[s+6], cap[s+7]});
      p = s + 8;
      rem = 504;
      while (rem >= len) begin
        mic = {7'd0, vna_exp & susers[exp_sidx & MASK][0]};
        for (int r = 0; r < nrx; r++) begin
          w = swords[exp_sidx & MASK];
          check_byte(name, p, w[23:16], cap[p]);
          check_byte(name, p + 1, w[15:8], cap[p+1]);
          check_byte(name, p + 2, w[7:0], cap[p+2]);
          p += 3;
          exp_sidx++;
        end
        check_byte(name, p, 8'h00, cap[p]);
        check_byte(name, p + 1, mic, cap[p+1]);
        p += 2;
        rem -= len;
      end
      for (; p < s + 512; p++) check_byte(name, p, 8'h00, cap[p]);  // Padding
    end
    check_len({name, " resp_rqst toggles"}, 11'd2, 11'(toggles));
    exp_ep6_seq = exp_ep6_seq + 20'd1;
  endtask

  task automatic check_ep4(string name);
    logic [11:0] w;
    check_header(name, 8'h04, exp_ep4_seq);
    for (int k = 0; k < 512; k++) begin
      w = bwords[exp_bidx & MASK];
      check_byte(name, 8 + 2 * k, {w[3:0], 4'h0}, cap[8+2*k]);
      check_byte(name, 9 + 2 * k, w[11:4], cap[9+2*k]);
      exp_bidx++;
    end
    exp_ep4_seq = exp_ep4_seq + 20'd1;
  endtask

  task automatic test_ep6_headers();
    set_rx(1, 2'd0);
    run = 1'b1;
    have_ip = 1'b1;
    fill = 1500;
    fill_period = 1;
    svalid = 1'b1;
    for (int f = 0; f < 3; f++) begin
      get_frame("ep6 header", 11'd1032);
      check_ep6("ep6 header");
    end
    svalid = 1'b0;
    run = 1'b0;
    repeat (5) next_cycle();
    run = 1'b1;
    exp_ep6_seq = '0;  // Numbering restarts with run
    svalid = 1'b1;
    get_frame("ep6 restart", 11'd1032);
    svalid = 1'b0;
    check_ep6("ep6 restart");
  endtask

  task automatic test_no_start();
    fill_period = 0;
    fill = 333;
    svalid = 1'b1;
    expect_quiet("fill at threshold", 60);
    fill = 1500;
    have_ip = 1'b0;
    expect_quiet("no ip address", 60);
    svalid = 1'b0;
    have_ip = 1'b1;
    fill_period = 1;
  endtask

  task automatic test_samples();
    us_pkg::us_cmd_u d;
    set_rx(3, 2'd0);
    d = '0;
    d.vna_cfg.vna = 1'b1;
    send_cmd(6'd9, d);
    vna_exp = 1'b1;
    svalid = 1'b1;
    for (int f = 0; f < 2; f++) begin
      get_frame("sample packing", 11'd1032);
      check_ep6("sample packing");
    end
    svalid = 1'b0;
  endtask

  task automatic test_wideband();
    int ep4_seen, ep6_run;
    logic wd_prev;
    us_pkg::us_cfg_t exp, obs;
    set_rx(2, 2'd1);
    run = 1'b0;
    repeat (5) next_cycle();
    run = 1'b1;
    exp_ep6_seq = '0;
    exp_ep4_seq = '0;
    fill = 340;
    fill_period = 8;  // Slow refill leaves idle gaps for EP4
    wide_spectrum = 1'b1;
    bvalid = 1'b1;
    svalid = 1'b1;
    wd_prev = watchdog_up;
    ep4_seen = 0;
    ep6_run = 0;
    for (int f = 0; f < 20 && ep4_seen < 3; f++) begin
      get_frame("wideband", 11'd1032);
      if (cap[3] == 8'h04) begin
        check_byte("watchdog toggle", 0, {7'd0, ~wd_prev}, {7'd0, watchdog_up});
        wd_prev = watchdog_up;
        check_ep4("ep4 frame");
        if (ep4_seen > 0) begin
          exp.bs_interval = 7'd4;
          exp.vna = vna_exp;
          obs.bs_interval = 7'(ep6_run);
          obs.vna = u_dut.cfg.vna;
          check_cfg("wideband interval", exp, obs);
        end
        ep4_seen++;
        ep6_run = 0;
      end else begin
        check_ep6("wideband ep6");
        ep6_run++;
      end
    end
    if (ep4_seen < 3) fail_stop("wideband: too few EP4 frames arrived");
    svalid = 1'b0;
    bvalid = 1'b0;
  endtask

  initial begin
    us_pkg::us_cfg_t rst_cfg;
    void'($urandom(32'hf02ca511));
    for (int i = 0; i <= MASK; i++) begin
      swords[i] = 24'($urandom);
      susers[i] = 2'($urandom);
      bwords[i] = 12'($urandom);
    end
    rst_n = 1'b0;
    cmd = '0;
    ident = '{48'h00_1c_c0_a2_13_5d, 32'hc0a8_0164, 16'h4b2e, 8'ha5, 1'b1};
    resp = 40'h8a_1b_2c_3d_4e;
    {run, have_ip, wide_spectrum, discovery, udp_tx_enable} = '0;
    {svalid, bvalid, pop_s, pop_b, vna_exp} = '0;
    {sidx, bidx, exp_sidx, exp_bidx, fill, fill_period} = '0;
    nrx = 1;
    exp_ep6_seq = '0;
    exp_ep4_seq = '0;
    repeat (10) next_cycle();
    rst_n = 1'b1;
    next_cycle();
    check_byte("reset outputs", 0, 8'h00,
               {3'b000, udp_tx_request, us_tready, bs_tready, resp_rqst, watchdog_up});
    rst_cfg.bs_interval = 7'd1;
    rst_cfg.vna = 1'b0;
    check_cfg("reset", rst_cfg, u_dut.cfg);
    test_discovery(1'b0);
    test_discovery(1'b1);
    test_ep6_headers();
    test_no_start();
    test_samples();
    test_wideband();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- testbench/us_packer_props.sv
// Protocol assertions for the frame sequencer, attached to every us_frame_packer by bind
`timescale 1ns/10ps

module us_packer_props (
  input logic        clk,
  input logic        rst_n,
  input logic        udp_tx_request,
  input logic        udp_tx_enable,
  input logic [10:0] udp_tx_length,
  input logic        us_tready,
  input logic        bs_tready
);

  logic [10:0] bytes_left;  // Payload bytes still owed after the enable cycle

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bytes_left <= '0;
    end else if (udp_tx_request && udp_tx_enable) begin
      bytes_left <= udp_tx_length;
    end else if (bytes_left != 11'd0) begin
      bytes_left <= bytes_left - 11'd1;
    end
  end

  // Request and length hold until the transmitter answers
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    udp_tx_request && !udp_tx_enable |=> udp_tx_request && $stable(udp_tx_length))
    else $error("udp_tx_request dropped or length changed before udp_tx_enable");

  a_pop_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(us_tready && bs_tready))
    else $error("sample and bandscope pops in the same cycle");

  a_pop_stream: assert property (@(posedge clk) disable iff (!rst_n)
    (us_tready || bs_tready) |-> (bytes_left != 11'd0))
    else $error("pop outside frame streaming");

endmodule

bind us_frame_packer us_packer_props u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .udp_tx_request (udp_tx_request),
  .udp_tx_enable  (udp_tx_enable),
  .udp_tx_length  (udp_tx_length),
  .us_tready      (us_tready),
  .bs_tready      (bs_tready)
);
